// File: design/guard_consts.svh
// Capability guard constants
`ifndef GUARD_CONSTS_SVH
`define GUARD_CONSTS_SVH

// Bus and field widths
`define ADDR_W    32
`define LEN_W     33
`define DATA_W    64
`define SEL_W     8
`define CFG_W     32
`define CFG_ADR_W 3

// Configuration word indices
`define SCR_DDC_BASE   3'd0
`define SCR_DDC_LEN_LO 3'd1
`define SCR_DDC_CTRL   3'd2
`define SCR_FAULT_VEC  3'd3
`define SCR_FAULT_ADR  3'd4

// Root capability, covers the whole 4 GiB space
`define DDC_RESET_TAG   1'b1
`define DDC_RESET_PERMS 4'b1111
`define DDC_RESET_BASE  32'h0000_0000
`define DDC_RESET_LEN   33'h1_0000_0000

`endif

// File: design/cap_pkg.sv
// Capability types
`default_nettype none

`include "guard_consts.svh"

package cap_pkg;

  // Permission bits, load in the MSB
  typedef struct packed {
    logic load;
    logic store;
    logic load_cap;
    logic store_cap;
  } cap_perms_t;

  // Uncompressed capability
  typedef struct packed {
    logic                tag;
    cap_perms_t          perms;
    logic [`ADDR_W-1:0]  base;
    logic [`LEN_W-1:0]   length;
  } cap_t;

  // Fault flags, any combination may be set
  typedef struct packed {
    logic tag_violation;
    logic perm_load;
    logic perm_store;
    logic perm_store_cap;
    logic bounds;
    logic misaligned;
  } cap_exc_t;

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
// Memory access and register index types
`default_nettype none

`include "guard_consts.svh"

package mem_pkg;

  // Same ordering as the core's data type field
  typedef enum logic [1:0] {
    ACC_WORD = 2'b00,
    ACC_HALF = 2'b01,
    ACC_BYTE = 2'b10,
    ACC_CAP  = 2'b11
  } access_type_e;

  // Configuration port word index
  typedef enum logic [`CFG_ADR_W-1:0] {
    DDC_BASE   = `SCR_DDC_BASE,
    DDC_LEN_LO = `SCR_DDC_LEN_LO,
    DDC_CTRL   = `SCR_DDC_CTRL,
    FAULT_VEC  = `SCR_FAULT_VEC,
    FAULT_ADR  = `SCR_FAULT_ADR
  } scr_idx_e;

endpackage

`default_nettype wire

// File: design/cap_checker.sv
// Data capability checker
`timescale 1ns/10ps
`default_nettype none

`include "guard_consts.svh"

module cap_checker (
  input  cap_pkg::cap_t         ddc_i,
  input  logic [`ADDR_W-1:0]    req_adr_i,
  input  mem_pkg::access_type_e req_type_i,
  input  logic                  req_we_i,
  input  logic [`DATA_W-1:0]    req_wdata_i,
  input  logic                  req_wtag_i,
  input  logic [`DATA_W-1:0]    mem_rdata_i,
  input  logic                  mem_rtag_i,
  output cap_pkg::cap_exc_t     exc_o,
  output logic [`SEL_W-1:0]     sel_o,
  output logic [`DATA_W-1:0]    mem_wdata_o,
  output logic                  mem_wtag_o,
  output logic [`DATA_W-1:0]    rdata_o,
  output logic                  rtag_o
);
  import mem_pkg::*;

  localparam int EndW = `LEN_W + 1;

  logic [3:0]         size;
  logic [2:0]         align_mask;
  logic [`SEL_W-1:0]  size_mask;
  logic [`DATA_W-1:0] data_mask;
  logic [2:0]         offset;
  logic [5:0]         lane_shift;
  logic [EndW-1:0]    acc_end;
  logic [EndW-1:0]    cap_end;
  logic               is_cap;

  // Size, alignment and lane masks per access type
  always_comb begin
    unique case (req_type_i)
      ACC_HALF: begin
        size       = 4'd2;
        align_mask = 3'b001;
        size_mask  = 8'b0000_0011;
        data_mask  = 64'h0000_0000_0000_ffff;
      end
      ACC_BYTE: begin
        size       = 4'd1;
        align_mask = 3'b000;
        size_mask  = 8'b0000_0001;
        data_mask  = 64'h0000_0000_0000_00ff;
      end
      ACC_CAP: begin
        size       = 4'd8;
        align_mask = 3'b111;
        size_mask  = 8'b1111_1111;
        data_mask  = '1;
      end
      default: begin
        size       = 4'd4;
        align_mask = 3'b011;
        size_mask  = 8'b0000_1111;
        data_mask  = 64'h0000_0000_ffff_ffff;
      end
    endcase
  end

  assign is_cap     = (req_type_i == ACC_CAP);
  assign offset     = req_adr_i[2:0];
  assign lane_shift = {offset, 3'b000};

  // One bit wider than the length so base + length cannot wrap
  assign acc_end = EndW'(req_adr_i) + EndW'(size);
  assign cap_end = EndW'(ddc_i.base) + EndW'(ddc_i.length);

  ////////////////////////////////////////////////////////////
  // Fault flags
  assign exc_o.tag_violation  = ~ddc_i.tag;
  assign exc_o.perm_load      = ~req_we_i & ~ddc_i.perms.load;
  assign exc_o.perm_store     = req_we_i & ~ddc_i.perms.store;
  assign exc_o.perm_store_cap = req_we_i & is_cap & req_wtag_i & ~ddc_i.perms.store_cap;
  assign exc_o.bounds         = (req_adr_i < ddc_i.base) | (acc_end > cap_end);
  assign exc_o.misaligned     = |(offset & align_mask);

  ////////////////////////////////////////////////////////////
  // Byte lanes and tags
  assign sel_o       = size_mask << offset;
  assign mem_wdata_o = req_wdata_i << lane_shift;
  // Plain stores clear the memory tag
  assign mem_wtag_o  = is_cap & req_wtag_i;
  assign rdata_o     = (mem_rdata_i >> lane_shift) & data_mask;
  // Tag stripped without load_cap permission
  assign rtag_o      = is_cap & ddc_i.perms.load_cap & mem_rtag_i;

endmodule

`default_nettype wire

// File: design/scr_regs.sv
// DDC and fault status registers
`timescale 1ns/10ps
`default_nettype none

`include "guard_consts.svh"

module scr_regs (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   cfg_cyc_i,
  input  logic                   cfg_stb_i,
  input  logic                   cfg_we_i,
  input  logic [`CFG_ADR_W-1:0]  cfg_adr_i,
  input  logic [`CFG_W-1:0]      cfg_dat_i,
  output logic [`CFG_W-1:0]      cfg_dat_o,
  output logic                   cfg_ack_o,
  input  logic                   fault_valid_i,
  input  cap_pkg::cap_exc_t      fault_vec_i,
  input  logic [`ADDR_W-1:0]     fault_adr_i,
  output cap_pkg::cap_t          ddc_o
);
  import cap_pkg::*;
  import mem_pkg::*;

  logic               cfg_req;
  logic               cfg_wr;
  logic               fault_clr;
  scr_idx_e           idx;
  logic [`CFG_W-1:0]  rdata;
  logic               fault_set_q;
  cap_exc_t           fault_vec_q;
  logic [`ADDR_W-1:0] fault_adr_q;

  // Served only in the cycle before the ack
  assign cfg_req   = cfg_cyc_i & cfg_stb_i & ~cfg_ack_o;
  assign cfg_wr    = cfg_req & cfg_we_i;
  assign idx       = scr_idx_e'(cfg_adr_i);
  assign fault_clr = cfg_wr & (idx == FAULT_VEC);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_ack_o   <= 1'b0;
      ddc_o.tag   <= `DDC_RESET_TAG;
      ddc_o.perms <= `DDC_RESET_PERMS;
      ddc_o.base  <= `DDC_RESET_BASE;
      ddc_o.length <= `DDC_RESET_LEN;
      fault_set_q <= 1'b0;
    end else begin
      cfg_ack_o <= cfg_req;
      if (cfg_wr) begin
        case (idx)
          DDC_BASE:   ddc_o.base <= cfg_dat_i;
          DDC_LEN_LO: ddc_o.length[`ADDR_W-1:0] <= cfg_dat_i;
          DDC_CTRL: begin
            ddc_o.length[`LEN_W-1] <= cfg_dat_i[0];
            ddc_o.perms            <= cfg_dat_i[4:1];
            ddc_o.tag              <= cfg_dat_i[8];
          end
          default: ;
        endcase
      end
      // Sticky until FAULT_VEC is written
      if (fault_clr) begin
        fault_set_q <= 1'b0;
      end else if (fault_valid_i) begin
        fault_set_q <= 1'b1;
      end
    end
  end

  // First fault only
  always_ff @(posedge clk) begin
    if (fault_valid_i && !fault_set_q) begin
      fault_vec_q <= fault_vec_i;
      fault_adr_q <= fault_adr_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  always_comb begin
    case (idx)
      DDC_BASE:   rdata = ddc_o.base;
      DDC_LEN_LO: rdata = ddc_o.length[`ADDR_W-1:0];
      DDC_CTRL:   rdata = {23'b0, ddc_o.tag, 3'b000, ddc_o.perms, ddc_o.length[`LEN_W-1]};
      FAULT_VEC:  rdata = fault_set_q ? `CFG_W'(fault_vec_q) : '0;
      FAULT_ADR:  rdata = fault_set_q ? fault_adr_q : '0;
      default:    rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cfg_req) begin
      cfg_dat_o <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/mem_bridge.sv
// Host to memory request bridge
`timescale 1ns/10ps
`default_nettype none

`include "guard_consts.svh"

module mem_bridge (
  input  logic                  clk,
  input  logic                  rst_ni,
  // Host slave port
  input  logic                  host_cyc_i,
  input  logic                  host_stb_i,
  input  logic                  host_we_i,
  input  logic [`ADDR_W-1:0]    host_adr_i,
  input  mem_pkg::access_type_e host_type_i,
  input  logic [`DATA_W-1:0]    host_dat_i,
  input  logic                  host_tag_i,
  output logic [`DATA_W-1:0]    host_dat_o,
  output logic                  host_tag_o,
  output logic                  host_ack_o,
  output logic                  host_err_o,
  // Memory master port
  output logic                  mem_cyc_o,
  output logic                  mem_stb_o,
  output logic                  mem_we_o,
  output logic [`ADDR_W-1:0]    mem_adr_o,
  output logic [`SEL_W-1:0]     mem_sel_o,
  output logic [`DATA_W-1:0]    mem_dat_o,
  output logic                  mem_tag_o,
  input  logic                  mem_ack_i,
  // Latched request to the checker
  output logic [`ADDR_W-1:0]    req_adr_o,
  output mem_pkg::access_type_e req_type_o,
  output logic                  req_we_o,
  output logic [`DATA_W-1:0]    req_wdata_o,
  output logic                  req_wtag_o,
  // Checker results
  input  cap_pkg::cap_exc_t     exc_i,
  input  logic [`SEL_W-1:0]     sel_i,
  input  logic [`DATA_W-1:0]    wdata_i,
  input  logic                  wtag_i,
  input  logic [`DATA_W-1:0]    rdata_i,
  input  logic                  rtag_i,
  // Fault report
  output logic                  fault_valid_o,
  output logic [`ADDR_W-1:0]    fault_adr_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CHECK,
    S_MEM,
    S_RESP
  } state_e;

  state_e state_q;
  logic   req_start;
  logic   fault;

  assign req_start = (state_q == S_IDLE) & host_cyc_i & host_stb_i;
  assign fault     = |exc_i;

  ////////////////////////////////////////////////////////////
  // Control FSM
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= S_IDLE;
      host_ack_o    <= 1'b0;
      host_err_o    <= 1'b0;
      mem_cyc_o     <= 1'b0;
      mem_stb_o     <= 1'b0;
      fault_valid_o <= 1'b0;
    end else begin
      // Responses last one cycle
      host_ack_o    <= 1'b0;
      host_err_o    <= 1'b0;
      fault_valid_o <= 1'b0;
      unique case (state_q)
        S_IDLE: begin
          if (req_start) begin
            state_q <= S_CHECK;
          end
        end
        S_CHECK: begin
          if (fault) begin
            host_err_o    <= 1'b1;
            fault_valid_o <= 1'b1;
            state_q       <= S_RESP;
          end else begin
            mem_cyc_o <= 1'b1;
            mem_stb_o <= 1'b1;
            state_q   <= S_MEM;
          end
        end
        S_MEM: begin
          if (mem_ack_i) begin
            mem_cyc_o  <= 1'b0;
            mem_stb_o  <= 1'b0;
            host_ack_o <= 1'b1;
            state_q    <= S_RESP;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Request, verdict and read data registers
  always_ff @(posedge clk) begin
    if (req_start) begin
      req_adr_o   <= host_adr_i;
      req_type_o  <= host_type_i;
      req_we_o    <= host_we_i;
      req_wdata_o <= host_dat_i;
      req_wtag_o  <= host_tag_i;
    end
    if (state_q == S_CHECK) begin
      mem_sel_o <= sel_i;
      mem_dat_o <= wdata_i;
      mem_tag_o <= wtag_i;
    end
    if (state_q == S_MEM && mem_ack_i) begin
      host_dat_o <= rdata_i;
      host_tag_o <= rtag_i;
    end
  end

  // Whole 64-bit word, lanes picked by sel
  assign mem_adr_o   = {req_adr_o[`ADDR_W-1:3], 3'b000};
  assign mem_we_o    = req_we_o;
  assign fault_adr_o = req_adr_o;

endmodule

`default_nettype wire

// File: design/guard_top.sv
// Capability guard top level
`timescale 1ns/10ps
`default_nettype none

`include "guard_consts.svh"

module guard_top (
  input  logic                   clk,
  input  logic                   rst_ni,
  // Host slave port
  input  logic                   host_cyc_i,
  input  logic                   host_stb_i,
  input  logic                   host_we_i,
  input  logic [`ADDR_W-1:0]     host_adr_i,
  input  mem_pkg::access_type_e  host_type_i,
  input  logic [`DATA_W-1:0]     host_dat_i,
  input  logic                   host_tag_i,
  output logic [`DATA_W-1:0]     host_dat_o,
  output logic                   host_tag_o,
  output logic                   host_ack_o,
  output logic                   host_err_o,
  // Memory master port
  output logic                   mem_cyc_o,
  output logic                   mem_stb_o,
  output logic                   mem_we_o,
  output logic [`ADDR_W-1:0]     mem_adr_o,
  output logic [`SEL_W-1:0]      mem_sel_o,
  output logic [`DATA_W-1:0]     mem_dat_o,
  output logic                   mem_tag_o,
  input  logic [`DATA_W-1:0]     mem_dat_i,
  input  logic                   mem_tag_i,
  input  logic                   mem_ack_i,
  // Configuration slave port
  input  logic                   cfg_cyc_i,
  input  logic                   cfg_stb_i,
  input  logic                   cfg_we_i,
  input  logic [`CFG_ADR_W-1:0]  cfg_adr_i,
  input  logic [`CFG_W-1:0]      cfg_dat_i,
  output logic [`CFG_W-1:0]      cfg_dat_o,
  output logic                   cfg_ack_o
);
  import cap_pkg::*;
  import mem_pkg::*;

  cap_t               ddc;
  cap_exc_t           exc;
  logic [`ADDR_W-1:0] req_adr;
  access_type_e       req_type;
  logic               req_we;
  logic [`DATA_W-1:0] req_wdata;
  logic               req_wtag;
  logic [`SEL_W-1:0]  chk_sel;
  logic [`DATA_W-1:0] chk_wdata;
  logic               chk_wtag;
  logic [`DATA_W-1:0] chk_rdata;
  logic               chk_rtag;
  logic               fault_valid;
  logic [`ADDR_W-1:0] fault_adr;

  scr_regs scr_regs_i (
    .clk           ( clk         ),
    .rst_ni        ( rst_ni      ),
    .cfg_cyc_i     ( cfg_cyc_i   ),
    .cfg_stb_i     ( cfg_stb_i   ),
    .cfg_we_i      ( cfg_we_i    ),
    .cfg_adr_i     ( cfg_adr_i   ),
    .cfg_dat_i     ( cfg_dat_i   ),
    .cfg_dat_o     ( cfg_dat_o   ),
    .cfg_ack_o     ( cfg_ack_o   ),
    .fault_valid_i ( fault_valid ),
    .fault_vec_i   ( exc         ),
    .fault_adr_i   ( fault_adr   ),
    .ddc_o         ( ddc         )
  );

  cap_checker cap_checker_i (
    .ddc_i       ( ddc       ),
    .req_adr_i   ( req_adr   ),
    .req_type_i  ( req_type  ),
    .req_we_i    ( req_we    ),
    .req_wdata_i ( req_wdata ),
    .req_wtag_i  ( req_wtag  ),
    .mem_rdata_i ( mem_dat_i ),
    .mem_rtag_i  ( mem_tag_i ),
    .exc_o       ( exc       ),
    .sel_o       ( chk_sel   ),
    .mem_wdata_o ( chk_wdata ),
    .mem_wtag_o  ( chk_wtag  ),
    .rdata_o     ( chk_rdata ),
    .rtag_o      ( chk_rtag  )
  );

  mem_bridge mem_bridge_i (
    .clk           ( clk         ),
    .rst_ni        ( rst_ni      ),
    .host_cyc_i    ( host_cyc_i  ),
    .host_stb_i    ( host_stb_i  ),
    .host_we_i     ( host_we_i   ),
    .host_adr_i    ( host_adr_i  ),
    .host_type_i   ( host_type_i ),
    .host_dat_i    ( host_dat_i  ),
    .host_tag_i    ( host_tag_i  ),
    .host_dat_o    ( host_dat_o  ),
    .host_tag_o    ( host_tag_o  ),
    .host_ack_o    ( host_ack_o  ),
    .host_err_o    ( host_err_o  ),
    .mem_cyc_o     ( mem_cyc_o   ),
    .mem_stb_o     ( mem_stb_o   ),
    .mem_we_o      ( mem_we_o    ),
    .mem_adr_o     ( mem_adr_o   ),
    .mem_sel_o     ( mem_sel_o   ),
    .mem_dat_o     ( mem_dat_o   ),
    .mem_tag_o     ( mem_tag_o   ),
    .mem_ack_i     ( mem_ack_i   ),
    .req_adr_o     ( req_adr     ),
    .req_type_o    ( req_type    ),
    .req_we_o      ( req_we      ),
    .req_wdata_o   ( req_wdata   ),
    .req_wtag_o    ( req_wtag    ),
    .exc_i         ( exc         ),
    .sel_i         ( chk_sel     ),
    .wdata_i       ( chk_wdata   ),
    .wtag_i        ( chk_wtag    ),
    .rdata_i       ( chk_rdata   ),
    .rtag_i        ( chk_rtag    ),
    .fault_valid_o ( fault_valid ),
    .fault_adr_o   ( fault_adr   )
  );

endmodule

`default_nettype wire

// File: sim/mem_model.sv
// Tagged memory model
`timescale 1ns/10ps
`default_nettype none

`include "guard_consts.svh"

module mem_model (
  input  logic                clk,
  input  logic                rst_ni,
  input  logic                rand_delay_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [`ADDR_W-1:0]  adr_i,
  input  logic [`SEL_W-1:0]   sel_i,
  input  logic [`DATA_W-1:0]  dat_i,
  input  logic                tag_i,
  output logic [`DATA_W-1:0]  dat_o,
  output logic                tag_o,
  output logic                ack_o
);

  logic [`DATA_W-1:0] mem [64];
  logic               tags [64];
  logic [1:0]         wait_q;
  logic [5:0]         idx;

  assign idx = adr_i[8:3];

  initial begin
    for (int i = 0; i < 64; i++) begin
      // Each byte carries the word index
      mem[i]  = {8{2'b10, 6'(i)}};
      tags[i] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o  <= 1'b0;
      wait_q <= 2'd0;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        if (wait_q == 2'd0) begin
          ack_o <= 1'b1;
          // Next delay of 0 to 3 cycles
          wait_q <= rand_delay_i ? 2'($urandom % 4) : 2'd0;
          if (we_i) begin
            for (int b = 0; b < `SEL_W; b++) begin
              if (sel_i[b]) begin
                mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
              end
            end
            tags[idx] <= tag_i;
          end else begin
            dat_o <= mem[idx];
            tag_o <= tags[idx];
          end
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/guard_asserts.sv
// Bridge handshake assertions
`timescale 1ns/10ps
`default_nettype none

module guard_asserts (
  input logic clk,
  input logic rst_ni,
  input logic host_ack_i,
  input logic host_err_i,
  input logic mem_cyc_i,
  input logic mem_stb_i,
  input logic mem_ack_i
);

  ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_ni)
    !(host_ack_i && host_err_i))
    else $error("host ack and err high together");

  no_mem_on_fault: assert property (@(posedge clk) disable iff (!rst_ni)
    host_err_i |-> !mem_cyc_i)
    else $error("memory cycle during a fault response");

  stb_held: assert property (@(posedge clk) disable iff (!rst_ni)
    (mem_stb_i && !mem_ack_i) |=> mem_stb_i)
    else $error("mem_stb dropped before ack");

  ack_single: assert property (@(posedge clk) disable iff (!rst_ni)
    host_ack_i |=> !host_ack_i)
    else $error("host ack on two consecutive cycles");

endmodule

`default_nettype wire

// File: sim/tb_guard_top.sv
// Capability guard testbench
`timescale 1ns/10ps
`default_nettype none

`include "guard_consts.svh"

module tb_guard_top;
  import mem_pkg::*;

  typedef struct packed {
    logic               is_cfg;
    logic               we;
    logic [`ADDR_W-1:0] adr;
    access_type_e       typ;
    logic [`DATA_W-1:0] dat;
    logic               tag;
    logic               exp_err;
    logic [`DATA_W-1:0] exp_dat;
    logic               exp_tag;
    logic               mem_chk;
    logic [`DATA_W-1:0] exp_mem;
  } entry_t;

  logic clk;
  logic rst_ni;
  logic rand_delay;
  logic host_cyc_i, host_stb_i, host_we_i, host_tag_i;
  logic [`ADDR_W-1:0] host_adr_i;
  access_type_e host_type_i;
  logic [`DATA_W-1:0] host_dat_i, host_dat_o;
  logic host_tag_o, host_ack_o, host_err_o;
  logic mem_cyc, mem_stb, mem_we, mem_wtag, mem_rtag, mem_ack;
  logic [`ADDR_W-1:0] mem_adr;
  logic [`SEL_W-1:0] mem_sel;
  logic [`DATA_W-1:0] mem_wdata, mem_rdata;
  logic cfg_cyc_i, cfg_stb_i, cfg_we_i, cfg_ack_o;
  logic [`CFG_ADR_W-1:0] cfg_adr_i;
  logic [`CFG_W-1:0] cfg_dat_i, cfg_dat_o;

  entry_t table_q[$];
  string  name_q[$];
  int     errors;
  logic   table_ready;

  guard_top guard_top_i (
    .clk (clk), .rst_ni (rst_ni),
    .host_cyc_i (host_cyc_i), .host_stb_i (host_stb_i), .host_we_i (host_we_i),
    .host_adr_i (host_adr_i), .host_type_i (host_type_i), .host_dat_i (host_dat_i),
    .host_tag_i (host_tag_i), .host_dat_o (host_dat_o), .host_tag_o (host_tag_o),
    .host_ack_o (host_ack_o), .host_err_o (host_err_o),
    .mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb), .mem_we_o (mem_we),
    .mem_adr_o (mem_adr), .mem_sel_o (mem_sel), .mem_dat_o (mem_wdata),
    .mem_tag_o (mem_wtag), .mem_dat_i (mem_rdata), .mem_tag_i (mem_rtag),
    .mem_ack_i (mem_ack),
    .cfg_cyc_i (cfg_cyc_i), .cfg_stb_i (cfg_stb_i), .cfg_we_i (cfg_we_i),
    .cfg_adr_i (cfg_adr_i), .cfg_dat_i (cfg_dat_i), .cfg_dat_o (cfg_dat_o),
    .cfg_ack_o (cfg_ack_o)
  );

  mem_model mem_model_i (
    .clk (clk), .rst_ni (rst_ni), .rand_delay_i (rand_delay),
    .cyc_i (mem_cyc), .stb_i (mem_stb), .we_i (mem_we), .adr_i (mem_adr),
    .sel_i (mem_sel), .dat_i (mem_wdata), .tag_i (mem_wtag),
    .dat_o (mem_rdata), .tag_o (mem_rtag), .ack_o (mem_ack)
  );

  bind mem_bridge guard_asserts guard_asserts_i (
    .clk (clk), .rst_ni (rst_ni), .host_ack_i (host_ack_o), .host_err_i (host_err_o),
    .mem_cyc_i (mem_cyc_o), .mem_stb_i (mem_stb_o), .mem_ack_i (mem_ack_i)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Table builders
  task automatic add_store(input string name, input logic [31:0] adr, input access_type_e typ,
                           input logic [63:0] dat, input logic tag, input logic err,
                           input logic mchk, input logic [63:0] emem);
    table_q.push_back('{1'b0, 1'b1, adr, typ, dat, tag, err, 64'd0, 1'b0, mchk, emem});
    name_q.push_back(name);
  endtask

  task automatic add_load(input string name, input logic [31:0] adr, input access_type_e typ,
                          input logic err, input logic [63:0] edat, input logic etag);
    table_q.push_back('{1'b0, 1'b0, adr, typ, 64'd0, 1'b0, err, edat, etag, 1'b0, 64'd0});
    name_q.push_back(name);
  endtask

  task automatic add_cfg(input string name, input logic we, input logic [2:0] idx,
                         input logic [31:0] dat);
    table_q.push_back('{1'b1, we, {29'd0, idx}, ACC_WORD, {32'd0, dat}, 1'b0, 1'b0,
                        {32'd0, dat}, 1'b0, 1'b0, 64'd0});
    name_q.push_back(name);
  endtask

  task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("FAILED %s: expected %h, actual %h", name, exp, act);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus drivers
  task automatic run_host(input int i);
    entry_t e;
    logic   err;
    e = table_q[i];
    @(posedge clk);
    host_cyc_i  <= 1'b1;
    host_stb_i  <= 1'b1;
    host_we_i   <= e.we;
    host_adr_i  <= e.adr;
    host_type_i <= e.typ;
    host_dat_i  <= e.dat;
    host_tag_i  <= e.tag;
    do @(negedge clk); while (!host_ack_o && !host_err_o);
    err = host_err_o;
    if (err !== e.exp_err) report_value({name_q[i], " err"}, 64'(e.exp_err), 64'(err));
    if (!e.we && !err && host_dat_o !== e.exp_dat)
      report_value({name_q[i], " data"}, e.exp_dat, host_dat_o);
    if (!e.we && !err && host_tag_o !== e.exp_tag)
      report_value({name_q[i], " tag"}, 64'(e.exp_tag), 64'(host_tag_o));
    if (e.mem_chk && mem_model_i.mem[e.adr[8:3]] !== e.exp_mem)
      report_value({name_q[i], " memory"}, e.exp_mem, mem_model_i.mem[e.adr[8:3]]);
    @(posedge clk);
    host_cyc_i <= 1'b0;
    host_stb_i <= 1'b0;
  endtask

  task automatic run_cfg(input int i);
    entry_t e;
    e = table_q[i];
    @(posedge clk);
    cfg_cyc_i <= 1'b1;
    cfg_stb_i <= 1'b1;
    cfg_we_i  <= e.we;
    cfg_adr_i <= e.adr[2:0];
    cfg_dat_i <= e.dat[31:0];
    do @(negedge clk); while (!cfg_ack_o);
    if (!e.we && {32'd0, cfg_dat_o} !== e.exp_dat)
      report_value(name_q[i], e.exp_dat, {32'd0, cfg_dat_o});
    @(posedge clk);
    cfg_cyc_i <= 1'b0;
    cfg_stb_i <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  task automatic build_table();
    // Reset state and plain accesses under the root capability
    add_cfg("rst_base", 1'b0, 3'd0, 32'h0);
    add_cfg("rst_len", 1'b0, 3'd1, 32'h0);
    add_cfg("rst_ctrl", 1'b0, 3'd2, 32'h11f);
    add_cfg("rst_fvec", 1'b0, 3'd3, 32'h0);
    add_cfg("rst_fadr", 1'b0, 3'd4, 32'h0);
    add_store("st_cap", 32'h100, ACC_CAP, 64'h1122_3344_5566_7788, 1'b0, 1'b0, 1'b1,
              64'h1122_3344_5566_7788);
    add_store("st_word4", 32'h104, ACC_WORD, 64'haabb_ccdd, 1'b0, 1'b0, 1'b1,
              64'haabb_ccdd_5566_7788);
    add_store("st_half2", 32'h102, ACC_HALF, 64'h1234, 1'b0, 1'b0, 1'b1,
              64'haabb_ccdd_1234_7788);
    add_store("st_byte1", 32'h101, ACC_BYTE, 64'hee, 1'b0, 1'b0, 1'b1,
              64'haabb_ccdd_1234_ee88);
    add_store("st_byte7", 32'h107, ACC_BYTE, 64'h99, 1'b0, 1'b0, 1'b1,
              64'h99bb_ccdd_1234_ee88);
    add_load("ld_word0", 32'h100, ACC_WORD, 1'b0, 64'h1234_ee88, 1'b0);
    add_load("ld_word4", 32'h104, ACC_WORD, 1'b0, 64'h99bb_ccdd, 1'b0);
    add_load("ld_half0", 32'h100, ACC_HALF, 1'b0, 64'hee88, 1'b0);
    add_load("ld_half2", 32'h102, ACC_HALF, 1'b0, 64'h1234, 1'b0);
    add_load("ld_half4", 32'h104, ACC_HALF, 1'b0, 64'hccdd, 1'b0);
    add_load("ld_half6", 32'h106, ACC_HALF, 1'b0, 64'h99bb, 1'b0);
    add_load("ld_byte0", 32'h100, ACC_BYTE, 1'b0, 64'h88, 1'b0);
    add_load("ld_byte1", 32'h101, ACC_BYTE, 1'b0, 64'hee, 1'b0);
    add_load("ld_byte2", 32'h102, ACC_BYTE, 1'b0, 64'h34, 1'b0);
    add_load("ld_byte3", 32'h103, ACC_BYTE, 1'b0, 64'h12, 1'b0);
    add_load("ld_byte4", 32'h104, ACC_BYTE, 1'b0, 64'hdd, 1'b0);
    add_load("ld_byte5", 32'h105, ACC_BYTE, 1'b0, 64'hcc, 1'b0);
    add_load("ld_byte6", 32'h106, ACC_BYTE, 1'b0, 64'hbb, 1'b0);
    add_load("ld_byte7", 32'h107, ACC_BYTE, 1'b0, 64'h99, 1'b0);
    add_load("ld_cap", 32'h100, ACC_CAP, 1'b0, 64'h99bb_ccdd_1234_ee88, 1'b0);
    // Tagged capability round trip
    add_store("st_cap_tag", 32'h108, ACC_CAP, 64'h0123_4567_89ab_cdef, 1'b1, 1'b0, 1'b1,
              64'h0123_4567_89ab_cdef);
    add_load("ld_cap_tag", 32'h108, ACC_CAP, 1'b0, 64'h0123_4567_89ab_cdef, 1'b1);
    // Misaligned accesses record only the first fault
    add_load("mis_half", 32'h101, ACC_HALF, 1'b1, 64'h0, 1'b0);
    add_load("mis_word", 32'h106, ACC_WORD, 1'b1, 64'h0, 1'b0);
    add_store("mis_cap", 32'h104, ACC_CAP, 64'h0, 1'b0, 1'b1, 1'b1, 64'h99bb_ccdd_1234_ee88);
    add_cfg("mis_fvec", 1'b0, 3'd3, 32'h01);
    add_cfg("mis_fadr", 1'b0, 3'd4, 32'h101);
    add_cfg("mis_clr", 1'b1, 3'd3, 32'h0);
    add_cfg("mis_fvec_clr", 1'b0, 3'd3, 32'h0);
    // Small load-only window at 0x200
    add_store("st_win", 32'h200, ACC_CAP, 64'h5555_aaaa_5555_aaaa, 1'b1, 1'b0, 1'b1,
              64'h5555_aaaa_5555_aaaa);
    add_cfg("win_base", 1'b1, 3'd0, 32'h200);
    add_cfg("win_len", 1'b1, 3'd1, 32'h40);
    add_cfg("win_ctrl", 1'b1, 3'd2, 32'h110);
    add_cfg("win_ctrl_rd", 1'b0, 3'd2, 32'h110);
    add_load("win_ld_word", 32'h200, ACC_WORD, 1'b0, 64'h5555_aaaa, 1'b0);
    add_load("win_ld_cap", 32'h200, ACC_CAP, 1'b0, 64'h5555_aaaa_5555_aaaa, 1'b0);
    add_load("win_ld_top", 32'h240, ACC_WORD, 1'b1, 64'h0, 1'b0);
    add_load("win_ld_below", 32'h1fc, ACC_WORD, 1'b1, 64'h0, 1'b0);
    add_load("win_ld_last", 32'h23c, ACC_WORD, 1'b0, 64'h8787_8787, 1'b0);
    add_store("win_st", 32'h208, ACC_WORD, 64'hdead_beef, 1'b0, 1'b1, 1'b1,
              64'h8181_8181_8181_8181);
    add_cfg("bnd_fvec", 1'b0, 3'd3, 32'h02);
    add_cfg("bnd_fadr", 1'b0, 3'd4, 32'h240);
    add_cfg("bnd_clr", 1'b1, 3'd3, 32'h0);
    add_store("win_st2", 32'h208, ACC_WORD, 64'hdead_beef, 1'b0, 1'b1, 1'b1,
              64'h8181_8181_8181_8181);
    add_cfg("st_fvec", 1'b0, 3'd3, 32'h08);
    add_cfg("st_fadr", 1'b0, 3'd4, 32'h208);
    add_cfg("st_clr", 1'b1, 3'd3, 32'h0);
    // Cleared DDC tag
    add_cfg("untag_ctrl", 1'b1, 3'd2, 32'h01e);
    add_load("untag_ld", 32'h200, ACC_WORD, 1'b1, 64'h0, 1'b0);
    add_store("untag_st", 32'h200, ACC_CAP, 64'h0, 1'b0, 1'b1, 1'b1, 64'h5555_aaaa_5555_aaaa);
    add_cfg("untag_fvec", 1'b0, 3'd3, 32'h20);
    add_cfg("untag_fadr", 1'b0, 3'd4, 32'h200);
    add_cfg("untag_clr", 1'b1, 3'd3, 32'h0);
    // No store_cap permission
    add_cfg("nsc_ctrl", 1'b1, 3'd2, 32'h11c);
    add_store("nsc_st_tag", 32'h208, ACC_CAP, 64'h1234, 1'b1, 1'b1, 1'b1,
              64'h8181_8181_8181_8181);
    add_store("nsc_st_plain", 32'h210, ACC_CAP, 64'h0f0f_0f0f_0f0f_0f0f, 1'b0, 1'b0, 1'b1,
              64'h0f0f_0f0f_0f0f_0f0f);
    add_cfg("nsc_fvec", 1'b0, 3'd3, 32'h04);
    add_cfg("nsc_fadr", 1'b0, 3'd4, 32'h208);
    add_cfg("nsc_clr", 1'b1, 3'd3, 32'h0);
    // No load permission
    add_cfg("nld_ctrl", 1'b1, 3'd2, 32'h10e);
    add_load("nld_ld", 32'h210, ACC_WORD, 1'b1, 64'h0, 1'b0);
    add_cfg("nld_fvec", 1'b0, 3'd3, 32'h10);
    add_cfg("nld_fadr", 1'b0, 3'd4, 32'h210);
    add_cfg("nld_clr", 1'b1, 3'd3, 32'h0);
    // Root capability restored before a byte store strips the tag
    add_cfg("root_base", 1'b1, 3'd0, 32'h0);
    add_cfg("root_len", 1'b1, 3'd1, 32'h0);
    add_cfg("root_ctrl", 1'b1, 3'd2, 32'h11f);
    add_store("clr_byte", 32'h108, ACC_BYTE, 64'h77, 1'b0, 1'b0, 1'b1, 64'h0123_4567_89ab_cd77);
    add_load("clr_ld_cap", 32'h108, ACC_CAP, 1'b0, 64'h0123_4567_89ab_cd77, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial begin
    void'($urandom(32'hdf18));
    clk = 1'b0;
    rst_ni = 1'b0;
    rand_delay = 1'b0;
    host_cyc_i = 1'b0;
    host_stb_i = 1'b0;
    host_we_i = 1'b0;
    host_adr_i = '0;
    host_type_i = ACC_WORD;
    host_dat_i = '0;
    host_tag_i = 1'b0;
    cfg_cyc_i = 1'b0;
    cfg_stb_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_adr_i = '0;
    cfg_dat_i = '0;
    errors = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst_ni <= 1'b1;
    // Second pass with random memory ack delays
    for (int pass = 0; pass < 2; pass++) begin
      rand_delay <= (pass == 1);
      for (int i = 0; i < table_q.size(); i++) begin
        if (table_q[i].is_cfg) run_cfg(i);
        else run_host(i);
      end
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per entry and pass
  initial begin
    wait (table_ready);
    repeat (2 * table_q.size() * 20) @(posedge clk);
    $display("Watchdog timeout, the test table did not complete in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/cap_pkg.sv
design/mem_pkg.sv
design/cap_checker.sv
design/scr_regs.sv
design/mem_bridge.sv
design/guard_top.sv
sim/mem_model.sv
sim/guard_asserts.sv
sim/tb_guard_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the capability guard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_guard_top \
  -Mdir obj_dir \
  -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_guard_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
